//--- common/hack_defines.svh
`ifndef HACK_DEFINES_SVH
`define HACK_DEFINES_SVH

// ---------------------------------------------------------------------------
// Datapath widths
// ---------------------------------------------------------------------------

`define HACK_WORD_W 16  // Data word, A and D registers
`define HACK_ADDR_W 15  // Data address and PC

// ---------------------------------------------------------------------------
// Reset values
// ---------------------------------------------------------------------------

// First instruction fetched after reset
`define HACK_PC_RESET 15'd0

`endif

//--- common/hack_pkg.sv
package hack_pkg;

    // -----------------------------------------------------------------------
    // ALU control and status
    // -----------------------------------------------------------------------

    // Comp bits c1..c6 in instruction order
    typedef struct packed {
        logic zx;  // Zero x
        logic nx;  // Invert x
        logic zy;  // Zero y
        logic ny;  // Invert y
        logic f;   // 1 add, 0 and
        logic no;  // Invert output
    } hack_alu_ctrl_t;

    typedef struct packed {
        logic zr;  // Result is zero
        logic ng;  // Result is negative
    } hack_alu_flags_t;

    // -----------------------------------------------------------------------
    // Decoded instruction
    // -----------------------------------------------------------------------

    // Dest and jump are already zero for A-instructions
    typedef struct packed {
        logic           is_c;    // C-instruction
        logic           sel_m;   // Operand y from M instead of A
        hack_alu_ctrl_t alu;
        logic           dest_a;
        logic           dest_d;
        logic           dest_m;
        logic [2:0]     jump;    // lt, eq, gt
    } hack_ctrl_t;

endpackage

//--- hw/hack_alu.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_alu (
    input  logic [`HACK_WORD_W-1:0]  i_x,
    input  logic [`HACK_WORD_W-1:0]  i_y,
    input  hack_pkg::hack_alu_ctrl_t i_ctrl,
    output logic [`HACK_WORD_W-1:0]  o_result,
    output hack_pkg::hack_alu_flags_t o_flags
);

    logic [`HACK_WORD_W-1:0] x_zero;
    logic [`HACK_WORD_W-1:0] x_op;
    logic [`HACK_WORD_W-1:0] y_zero;
    logic [`HACK_WORD_W-1:0] y_op;
    logic [`HACK_WORD_W-1:0] fn_out;

    // -----------------------------------------------------------------------
    // Input stages
    // -----------------------------------------------------------------------

    always_comb begin
        x_zero = i_ctrl.zx ? '0 : i_x;
        x_op   = i_ctrl.nx ? ~x_zero : x_zero;
    end

    always_comb begin
        y_zero = i_ctrl.zy ? '0 : i_y;
        y_op   = i_ctrl.ny ? ~y_zero : y_zero;
    end

    // -----------------------------------------------------------------------
    // Function and output stage
    // -----------------------------------------------------------------------

    always_comb begin
        if (i_ctrl.f) begin
            fn_out = x_op + y_op;  // Wraps at word width
        end else begin
            fn_out = x_op & y_op;
        end
    end

    assign o_result = i_ctrl.no ? ~fn_out : fn_out;

    // Two's complement sign is the top bit
    assign o_flags.zr = (o_result == '0);
    assign o_flags.ng = o_result[`HACK_WORD_W-1];

    // D-A goes through every stage, invert x, add, invert output
    always_comb begin
        assert final (i_ctrl != 6'b010011 || o_result == i_x - i_y)
            else $error("ALU D-A gave %h for %h - %h", o_result, i_x, i_y);
    end

endmodule

//--- hw/hack_decoder.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_decoder (
    input  logic [`HACK_WORD_W-1:0] i_instruction,
    output hack_pkg::hack_ctrl_t    o_ctrl
);

    logic       is_c;
    logic       a_bit;
    logic [5:0] comp;
    logic [2:0] dest;
    logic [2:0] jmp;

    // -----------------------------------------------------------------------
    // Instruction fields
    // -----------------------------------------------------------------------

    // C-instruction layout is 1 1 1 a c1..c6 d1 d2 d3 j1 j2 j3
    assign is_c  = i_instruction[`HACK_WORD_W-1];
    assign a_bit = i_instruction[12];
    assign comp  = i_instruction[11:6];
    assign dest  = i_instruction[5:3];   // A, D, M
    assign jmp   = i_instruction[2:0];   // lt, eq, gt

    // -----------------------------------------------------------------------
    // Control struct
    // -----------------------------------------------------------------------

    always_comb begin
        o_ctrl.is_c  = is_c;
        o_ctrl.alu   = comp;  // Don't care for A-instructions

        if (is_c) begin
            o_ctrl.sel_m  = a_bit;
            o_ctrl.dest_a = dest[2];
            o_ctrl.dest_d = dest[1];
            o_ctrl.dest_m = dest[0];
            o_ctrl.jump   = jmp;
        end else begin
            // Constant bits must not leak into any enable
            o_ctrl.sel_m  = 1'b0;
            o_ctrl.dest_a = 1'b0;
            o_ctrl.dest_d = 1'b0;
            o_ctrl.dest_m = 1'b0;
            o_ctrl.jump   = 3'b000;
        end
    end

endmodule

//--- hw/hack_pc.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_pc (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  logic [2:0]                i_jump,
    input  hack_pkg::hack_alu_flags_t i_flags,
    input  logic [`HACK_ADDR_W-1:0]   i_target,
    output logic [`HACK_ADDR_W-1:0]   o_pc
);

    logic                    is_pos;
    logic                    take_jump;
    logic [`HACK_ADDR_W-1:0] pc_next;

    // -----------------------------------------------------------------------
    // Jump condition
    // -----------------------------------------------------------------------

    assign is_pos = !i_flags.zr && !i_flags.ng;

    // JMP sets all three bits, so one of them always matches
    assign take_jump = (i_jump[2] && i_flags.ng)
                    || (i_jump[1] && i_flags.zr)
                    || (i_jump[0] && is_pos);

    assign pc_next = take_jump ? i_target : o_pc + 1'b1;  // Wraps at 15 bits

    // -----------------------------------------------------------------------
    // PC register
    // -----------------------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= `HACK_PC_RESET;
        end else begin
            o_pc <= pc_next;
        end
    end

    a_no_jump_inc: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (i_jump == 3'b000) |=> (o_pc == $past(o_pc) + 1'b1)
    ) else $error("PC did not increment on a non-jump instruction");

endmodule

//--- cpu/hack_cpu.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_cpu (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic [`HACK_WORD_W-1:0] i_instruction,
    input  logic [`HACK_WORD_W-1:0] i_in_m,
    output logic [`HACK_WORD_W-1:0] o_out_m,
    output logic                    o_write_m,
    output logic [`HACK_ADDR_W-1:0] o_address_m,
    output logic [`HACK_ADDR_W-1:0] o_pc
);

    import hack_pkg::*;

    hack_ctrl_t              ctrl;
    hack_alu_flags_t         alu_flags;
    logic [`HACK_WORD_W-1:0] a_reg;
    logic [`HACK_WORD_W-1:0] d_reg;
    logic [`HACK_WORD_W-1:0] alu_y;
    logic [`HACK_WORD_W-1:0] alu_result;

    // -----------------------------------------------------------------------
    // Decode and execute
    // -----------------------------------------------------------------------

    hack_decoder u_decoder (
        .i_instruction (i_instruction),
        .o_ctrl        (ctrl)
    );

    assign alu_y = ctrl.sel_m ? i_in_m : a_reg;  // a-bit picks M or A

    hack_alu u_alu (
        .i_x      (d_reg),
        .i_y      (alu_y),
        .i_ctrl   (ctrl.alu),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    // -----------------------------------------------------------------------
    // A and D registers
    // -----------------------------------------------------------------------

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            a_reg <= '0;
        end else if (!ctrl.is_c) begin
            a_reg <= {1'b0, i_instruction[`HACK_ADDR_W-1:0]};  // @constant
        end else if (ctrl.dest_a) begin
            a_reg <= alu_result;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            d_reg <= '0;
        end else if (ctrl.dest_d) begin
            d_reg <= alu_result;
        end
    end

    // -----------------------------------------------------------------------
    // Program counter
    // -----------------------------------------------------------------------

    // Jump target is the A value before this instruction writes it
    hack_pc u_pc (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_jump   (ctrl.jump),
        .i_flags  (alu_flags),
        .i_target (a_reg[`HACK_ADDR_W-1:0]),
        .o_pc     (o_pc)
    );

    // -----------------------------------------------------------------------
    // Memory side
    // -----------------------------------------------------------------------

    assign o_out_m     = alu_result;
    assign o_write_m   = ctrl.dest_m;  // Memory samples it at the next edge
    assign o_address_m = a_reg[`HACK_ADDR_W-1:0];

    a_no_write_on_a_instr: assert property (
        @(posedge i_clk) !i_instruction[`HACK_WORD_W-1] |-> !o_write_m
    ) else $error("Memory write strobe high for an A-instruction");

endmodule

//--- test/hack_cpu_checker.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_cpu_checker (
    input  logic                    i_clk,
    input  logic [`HACK_WORD_W-1:0] i_out_m,
    input  logic                    i_write_m,
    input  logic [`HACK_ADDR_W-1:0] i_address_m,
    input  logic [`HACK_ADDR_W-1:0] i_pc,
    input  logic                    i_valid,
    input  int                      i_row_idx,
    input  logic [`HACK_WORD_W-1:0] i_exp_out,
    input  logic                    i_out_care,
    input  logic                    i_exp_write,
    input  logic [`HACK_ADDR_W-1:0] i_exp_addr,
    input  logic [`HACK_ADDR_W-1:0] i_exp_pc,
    input  logic                    i_rst_row,
    output int                      o_pass_rows,
    output int                      o_fail_rows
);

    logic                    prev_valid = 1'b0;
    logic                    prev_err   = 1'b0;
    int                      prev_idx   = 0;
    logic [`HACK_ADDR_W-1:0] prev_pc    = '0;

    initial begin
        o_pass_rows = 0;
        o_fail_rows = 0;
    end

    function automatic logic mismatch(input string name, input logic [15:0] exp,
                                      input logic [15:0] act);
        if (exp !== act) begin
            $display("** Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // -----------------------------------------------------------------------
    // Sampling on the falling edge
    // -----------------------------------------------------------------------

    always @(negedge i_clk) begin
        logic err;
        err = 1'b0;
        // PC of the previous row, unless reset has just cleared it
        if (prev_valid) begin
            if (!(i_valid && i_rst_row)) begin
                prev_err |= mismatch("o_pc", 16'(prev_pc), 16'(i_pc));
            end
            if (prev_err) begin
                o_fail_rows++;
                $display("Row %0d failed", prev_idx);
            end else begin
                o_pass_rows++;
                $display("Row %0d passed", prev_idx);
            end
        end
        if (i_valid) begin
            if (i_out_care) begin
                err |= mismatch("o_out_m", i_exp_out, i_out_m);
            end
            err |= mismatch("o_write_m", 16'(i_exp_write), 16'(i_write_m));
            err |= mismatch("o_address_m", 16'(i_exp_addr), 16'(i_address_m));
            if (i_rst_row || !prev_valid) begin
                err |= mismatch("o_pc", 16'(`HACK_PC_RESET), 16'(i_pc));  // Reset state
            end
        end
        prev_err   = err;
        prev_pc    = i_exp_pc;
        prev_idx   = i_row_idx;
        prev_valid = i_valid;
    end

endmodule

//--- test/hack_cpu_tb.sv
`timescale 1ns/1ps
`include "hack_defines.svh"

module hack_cpu_tb;

    import hack_pkg::*;

    localparam int N_ROWS     = 48;
    localparam int RST_CYCLES = 16;
    localparam int PERIOD     = 100;
    localparam int TIMEOUT    = (N_ROWS * 2 + RST_CYCLES) * PERIOD;

    // Stimulus and expected values, one row per instruction
    typedef struct packed {
        logic [`HACK_WORD_W-1:0] instr;
        logic                    use_m;    // Row reads M, so in_m is fixed
        logic [`HACK_WORD_W-1:0] in_m;
        logic [`HACK_WORD_W-1:0] out_m;
        logic                    out_care;
        logic                    write_m;
        logic [`HACK_ADDR_W-1:0] addr;
        logic [`HACK_ADDR_W-1:0] pc;       // After the executing edge
        logic                    rst;      // Drop reset with this row
    } row_t;

    logic                    clk;
    logic                    arst_n;
    logic [`HACK_WORD_W-1:0] instruction;
    logic [`HACK_WORD_W-1:0] in_m;
    logic [`HACK_WORD_W-1:0] out_m;
    logic                    write_m;
    logic [`HACK_ADDR_W-1:0] address_m;
    logic [`HACK_ADDR_W-1:0] pc;

    logic                    row_valid;
    int                      row_idx;
    row_t                    cur;
    row_t                    table_rows [N_ROWS];
    int                      n_loaded;
    int                      pass_rows;
    int                      fail_rows;

    always #(PERIOD / 2) clk = ~clk;

    hack_cpu dut0 (
        .i_clk         (clk),
        .i_arst_n      (arst_n),
        .i_instruction (instruction),
        .i_in_m        (in_m),
        .o_out_m       (out_m),
        .o_write_m     (write_m),
        .o_address_m   (address_m),
        .o_pc          (pc)
    );

    hack_cpu_checker checker0 (
        .i_clk        (clk),
        .i_out_m      (out_m),
        .i_write_m    (write_m),
        .i_address_m  (address_m),
        .i_pc         (pc),
        .i_valid      (row_valid),
        .i_row_idx    (row_idx),
        .i_exp_out    (cur.out_m),
        .i_out_care   (cur.out_care),
        .i_exp_write  (cur.write_m),
        .i_exp_addr   (cur.addr),
        .i_exp_pc     (cur.pc),
        .i_rst_row    (cur.rst),
        .o_pass_rows  (pass_rows),
        .o_fail_rows  (fail_rows)
    );

    // -----------------------------------------------------------------------
    // Instruction encoding and table
    // -----------------------------------------------------------------------

    function automatic logic [15:0] encode_a(input logic [14:0] value);
        return {1'b0, value};
    endfunction

    function automatic logic [15:0] encode_c(input logic a, input logic [5:0] comp,
                                             input logic [2:0] dest, input logic [2:0] jmp);
        return {3'b111, a, comp, dest, jmp};
    endfunction

    task automatic add_row(input logic [15:0] instr, input logic use_m, input logic [15:0] m,
                           input logic [15:0] out, input logic care, input logic wr,
                           input logic [14:0] addr, input logic [14:0] pc_after,
                           input logic rst);
        table_rows[n_loaded] = '{instr, use_m, m, out, care, wr, addr, pc_after, rst};
        n_loaded++;
    endtask

    // PC after each jump code 000..111, starting pcs 14, 41 and 41
    logic [14:0] pos_pc  [8] = '{15'd15, 15'd40, 15'd41, 15'd40, 15'd41, 15'd40, 15'd41, 15'd40};
    logic [14:0] zero_pc [8] = '{15'd42, 15'd43, 15'd40, 15'd40, 15'd41, 15'd42, 15'd40, 15'd40};
    logic [14:0] neg_pc  [8] = '{15'd42, 15'd43, 15'd44, 15'd45, 15'd40, 15'd40, 15'd40, 15'd40};

    task automatic load_table();
        // A-instruction, D and M arithmetic
        add_row(encode_a(15'd100), 0, 0, 16'h0000, 0, 0, 15'd0, 15'd1, 0);
        add_row(encode_c(0, 6'b110000, 3'b010, 3'b000), 0, 0, 16'd100, 1, 0, 15'd100, 15'd2, 0);
        add_row(encode_a(15'd30), 0, 0, 16'h0000, 0, 0, 15'd100, 15'd3, 0);
        add_row(encode_c(0, 6'b010011, 3'b010, 3'b000), 0, 0, 16'd70, 1, 0, 15'd30, 15'd4, 0);
        add_row(encode_c(1, 6'b000010, 3'b010, 3'b000), 1, 16'd5, 16'd75, 1, 0, 15'd30, 15'd5, 0);
        add_row(encode_c(0, 6'b001110, 3'b001, 3'b000), 0, 0, 16'd74, 1, 1, 15'd30, 15'd6, 0);
        // Constants and negations into M, D is 75 and A is 30
        add_row(encode_c(0, 6'b101010, 3'b001, 3'b000), 0, 0, 16'h0000, 1, 1, 15'd30, 15'd7, 0);
        add_row(encode_c(0, 6'b111111, 3'b001, 3'b000), 0, 0, 16'h0001, 1, 1, 15'd30, 15'd8, 0);
        add_row(encode_c(0, 6'b111010, 3'b001, 3'b000), 0, 0, 16'hffff, 1, 1, 15'd30, 15'd9, 0);
        add_row(encode_c(0, 6'b001101, 3'b001, 3'b000), 0, 0, 16'hffb4, 1, 1, 15'd30, 15'd10, 0);
        add_row(encode_c(0, 6'b001111, 3'b001, 3'b000), 0, 0, 16'hffb5, 1, 1, 15'd30, 15'd11, 0);
        add_row(encode_c(0, 6'b010101, 3'b001, 3'b000), 0, 0, 16'h005f, 1, 1, 15'd30, 15'd12, 0);
        add_row(encode_c(1, 6'b000000, 3'b001, 3'b000), 1, 16'h00f0, 16'h0040, 1, 1, 15'd30,
                15'd13, 0);
        // Jumps to 40 with D positive, zero and negative
        add_row(encode_a(15'd40), 0, 0, 16'h0000, 0, 0, 15'd30, 15'd14, 0);
        foreach (pos_pc[k]) begin
            add_row(encode_c(0, 6'b001100, 3'b000, k[2:0]), 0, 0, 16'd75, 1, 0, 15'd40,
                    pos_pc[k], 0);
        end
        add_row(encode_c(0, 6'b101010, 3'b010, 3'b000), 0, 0, 16'h0000, 1, 0, 15'd40, 15'd41, 0);
        foreach (zero_pc[k]) begin
            add_row(encode_c(0, 6'b001100, 3'b000, k[2:0]), 0, 0, 16'h0000, 1, 0, 15'd40,
                    zero_pc[k], 0);
        end
        add_row(encode_c(0, 6'b111010, 3'b010, 3'b000), 0, 0, 16'hffff, 1, 0, 15'd40, 15'd41, 0);
        foreach (neg_pc[k]) begin
            add_row(encode_c(0, 6'b001100, 3'b000, k[2:0]), 0, 0, 16'hffff, 1, 0, 15'd40,
                    neg_pc[k], 0);
        end
        // A written by the ALU, then used as a jump target
        add_row(encode_c(0, 6'b110111, 3'b100, 3'b000), 0, 0, 16'd41, 1, 0, 15'd40, 15'd41, 0);
        add_row(encode_c(0, 6'b101010, 3'b000, 3'b111), 0, 0, 16'h0000, 1, 0, 15'd41, 15'd41, 0);
        add_row(encode_c(1, 6'b110111, 3'b101, 3'b000), 1, 16'h1233, 16'h1234, 1, 1, 15'd41,
                15'd42, 0);
        add_row(encode_c(0, 6'b001100, 3'b000, 3'b100), 0, 0, 16'hffff, 1, 0, 15'h1234,
                15'h1234, 0);
        add_row(encode_a(15'd3), 0, 0, 16'h0000, 0, 0, 15'h1234, 15'h1235, 0);
        // Reset in mid-program, A and D read as zero
        add_row(encode_c(0, 6'b011111, 3'b001, 3'b000), 0, 0, 16'h0001, 1, 1, 15'd0, 15'd0, 1);
        add_row(encode_a(15'd7), 0, 0, 16'h0000, 0, 0, 15'd0, 15'd1, 0);
        add_row(encode_c(0, 6'b110000, 3'b010, 3'b000), 0, 0, 16'd7, 1, 0, 15'd7, 15'd2, 0);
    endtask

    // -----------------------------------------------------------------------
    // Stimulus
    // -----------------------------------------------------------------------

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        instruction = '0;
        in_m        = '0;
        row_valid   = 1'b0;
        row_idx     = 0;
        cur         = '0;
        n_loaded    = 0;
        void'($urandom(91));
        load_table();
        if (n_loaded != N_ROWS) begin
            $display("Stimulus table holds %0d rows instead of %0d", n_loaded, N_ROWS);
        end
        repeat (RST_CYCLES) @(posedge clk);
        for (int i = 0; i < N_ROWS; i++) begin
            @(posedge clk);
            arst_n      <= !table_rows[i].rst;
            instruction <= table_rows[i].instr;
            in_m        <= table_rows[i].use_m ? table_rows[i].in_m : 16'($urandom);
            cur         <= table_rows[i];
            row_idx     <= i;
            row_valid   <= 1'b1;
        end
        @(posedge clk);
        row_valid <= 1'b0;
        @(negedge clk);
        #1;
        $display("Rows passed %0d, failed %0d", pass_rows, fail_rows);
        if (fail_rows == 0 && n_loaded == N_ROWS) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Run timed out after %0d ns before all rows finished", TIMEOUT);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- hack_cpu.f
+incdir+common
common/hack_pkg.sv
hw/hack_alu.sv
hw/hack_decoder.sv
hw/hack_pc.sv
cpu/hack_cpu.sv
test/hack_cpu_checker.sv
test/hack_cpu_tb.sv

//--- Bender.yml
package:
  name: hack_cpu

sources:
  - include_dirs:
      - common
    files:
      - common/hack_pkg.sv
      - hw/hack_alu.sv
      - hw/hack_decoder.sv
      - hw/hack_pc.sv
      - cpu/hack_cpu.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/hack_cpu_checker.sv
      - test/hack_cpu_tb.sv
